//--- Bender.yml
package:
  name: stq_fwd

sources:
  - stq_geom_pkg.sv
  - stq_result_pkg.sv
  - stq_entry.sv
  - stq_addr_cam.sv
  - stq_alloc.sv
  - stq_fwd_select.sv
  - stq_fwd_top.sv
  - target: test
    files:
      - stq_fwd_tb.sv

//--- stq_addr_cam.sv
/*
 * store-queue address CAM.
 * keeps the line address of every slot and compares both load-check
 * addresses against all of them in parallel.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_addr_cam
  import stq_geom_pkg::*;
#(
  parameter int ENTRIES = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [ENTRIES-1:0] wrt_en,
  input  addr_t              st_addr,
  input  addr_t              chk0_addr,
  input  addr_t              chk1_addr,
  output logic [ENTRIES-1:0] addr_hit0,
  output logic [ENTRIES-1:0] addr_hit1
);

  addr_t line_addr [ENTRIES];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        line_addr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ENTRIES; i++) begin
        if (wrt_en[i]) begin
          line_addr[i] <= st_addr;
        end
      end
    end
  end

  // compare lines, the slot flags qualify them.
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      addr_hit0[i] = (line_addr[i] == chk0_addr);
      addr_hit1[i] = (line_addr[i] == chk1_addr);
    end
  end

endmodule

`default_nettype wire

//--- stq_alloc.sv
/*
 * store-queue allocator.
 * ring pointers for allocate (tail), commit (cmt) and drain (head),
 * with occupancy counts, turning the control pulses into per-slot strobes.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_alloc #(
  parameter int ENTRIES = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       st_en,
  input  logic                       commit_en,
  input  logic                       drain_en,
  input  logic                       excpt,
  input  logic [ENTRIES-1:0]         free,
  input  logic [ENTRIES-1:0]         passe,
  output logic [ENTRIES-1:0]         wrt_en,
  output logic [ENTRIES-1:0]         commit_set,
  output logic [ENTRIES-1:0]         free_set,
  output logic                       flush,
  output logic [$clog2(ENTRIES)-1:0] tail,
  output logic                       st_full
);

  localparam int IDX_W = $clog2(ENTRIES);
  localparam int CNT_W = IDX_W + 1;

  logic [IDX_W-1:0] cmt;
  logic [IDX_W-1:0] head;
  // occupied slots, and the committed ones among them.
  logic [CNT_W-1:0] cnt_occ;
  logic [CNT_W-1:0] cnt_cmt;
  logic             do_wrt;
  logic             do_cmt;
  logic             do_drn;

  assign st_full = (cnt_occ == CNT_W'(ENTRIES));
  assign flush   = excpt;

  // the flush wins over a same-cycle allocate or commit.
  assign do_wrt = st_en && !st_full && !excpt;
  assign do_cmt = commit_en && (cnt_occ != cnt_cmt) && !excpt;
  assign do_drn = drain_en && !free[head] && passe[head];

  assign wrt_en     = do_wrt ? (ENTRIES'(1) << tail) : '0;
  assign commit_set = do_cmt ? (ENTRIES'(1) << cmt)  : '0;
  assign free_set   = do_drn ? (ENTRIES'(1) << head) : '0;

  ////////////////////
  // pointers and counts.
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      tail    <= '0;
      cmt     <= '0;
      head    <= '0;
      cnt_occ <= '0;
      cnt_cmt <= '0;
    end else begin
      head    <= head + IDX_W'(do_drn);
      cnt_cmt <= cnt_cmt + CNT_W'(do_cmt) - CNT_W'(do_drn);
      if (excpt) begin
        // only committed stores survive.
        tail    <= cmt;
        cnt_occ <= cnt_cmt - CNT_W'(do_drn);
      end else begin
        tail    <= tail + IDX_W'(do_wrt);
        cmt     <= cmt + IDX_W'(do_cmt);
        cnt_occ <= cnt_occ + CNT_W'(do_wrt) - CNT_W'(do_drn);
      end
    end
  end

endmodule

`default_nettype wire

//--- stq_entry.sv
/*
 * store-queue slot.
 * holds the bank and byte masks of one in-flight store with its
 * free, data-ready and committed flags, and flags a full match or a
 * partial overlap for each of the two load-check ports.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_entry
  import stq_geom_pkg::*;
#(
  parameter int ENTRIES = 8,
  parameter int IDX     = 0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wrt_en,
  input  bank_t                      banks,
  input  byte_t                      bytes,
  input  logic                       data_en,
  input  logic [$clog2(ENTRIES)-1:0] data_idx,
  input  logic                       commit_set,
  input  logic                       free_set,
  input  logic                       flush,
  input  logic                       addr_hit0,
  input  logic                       addr_hit1,
  input  logic                       chk0_en,
  input  bank_t                      chk0_banks,
  input  byte_t                      chk0_bytes,
  input  logic                       chk1_en,
  input  bank_t                      chk1_banks,
  input  byte_t                      chk1_bytes,
  output logic                       match0,
  output logic                       partial0,
  output logic                       match1,
  output logic                       partial1,
  output logic                       free,
  output logic                       passe
);

  localparam int IDX_W = $clog2(ENTRIES);

  bank_t banks_r;
  byte_t bytes_r;
  logic  upd;
  logic  data_hit;
  logic  live;
  logic  overlap0;
  logic  overlap1;
  logic  covered0;
  logic  covered1;

  assign data_hit = data_en && (data_idx == IDX_W'(IDX));

  // only occupied, uncommitted stores answer a check.
  assign live = !free && !passe;

  assign overlap0 = chk0_en && live && addr_hit0 && ((chk0_banks & banks_r) != '0);
  assign overlap1 = chk1_en && live && addr_hit1 && ((chk1_banks & banks_r) != '0);

  // load bytes must lie inside the store bytes.
  assign covered0 = (chk0_bytes & ~bytes_r) == '0;
  assign covered1 = (chk1_bytes & ~bytes_r) == '0;

  assign match0   = overlap0 && upd && covered0;
  assign partial0 = overlap0 && (!upd || !covered0);
  assign match1   = overlap1 && upd && covered1;
  assign partial1 = overlap1 && (!upd || !covered1);

  always_ff @(posedge clk) begin
    if (wrt_en) begin
      banks_r <= banks;
      bytes_r <= bytes;
    end
  end

  ////////////////////
  // status flags, later updates take precedence.
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      free  <= 1'b1;
      upd   <= 1'b0;
      passe <= 1'b0;
    end else begin
      if (wrt_en) begin
        free  <= 1'b0;
        upd   <= 1'b0;
        passe <= 1'b0;
      end
      if (data_hit) begin
        upd <= 1'b1;
      end
      if (commit_set) begin
        passe <= 1'b1;
      end
      if (free_set) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end
      // an exception drops every store that has not committed.
      if (flush && live) begin
        free <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- stq_fwd.f
stq_geom_pkg.sv
stq_result_pkg.sv
stq_entry.sv
stq_addr_cam.sv
stq_alloc.sv
stq_fwd_select.sv
stq_fwd_top.sv
stq_fwd_tb.sv

//--- stq_fwd_select.sv
/*
 * forwarding selector.
 * per check port, reports a stall on any partial overlap, else the
 * youngest matching slot in ring order, else a miss, one clock later.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_fwd_select
  import stq_result_pkg::*;
#(
  parameter int ENTRIES = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [$clog2(ENTRIES)-1:0] tail,
  input  logic                       chk0_en,
  input  logic                       chk1_en,
  input  logic [ENTRIES-1:0]         match0,
  input  logic [ENTRIES-1:0]         partial0,
  input  logic [ENTRIES-1:0]         match1,
  input  logic [ENTRIES-1:0]         partial1,
  output logic                       chk0_valid,
  output logic                       chk1_valid,
  output fwd_result_e                chk0_result,
  output fwd_result_e                chk1_result,
  output logic [$clog2(ENTRIES)-1:0] chk0_idx,
  output logic [$clog2(ENTRIES)-1:0] chk1_idx
);

  localparam int IDX_W = $clog2(ENTRIES);

  fwd_result_e      res0;
  fwd_result_e      res1;
  logic [IDX_W-1:0] idx0;
  logic [IDX_W-1:0] idx1;

  // walks back from tail-1; the closest hit to tail is the youngest.
  function automatic logic [IDX_W-1:0] youngest(input logic [ENTRIES-1:0] hits,
                                                input logic [IDX_W-1:0]   ptr);
    logic [IDX_W-1:0] pos;
    logic [IDX_W-1:0] sel;
    sel = '0;
    for (int k = ENTRIES; k >= 1; k--) begin
      pos = ptr - IDX_W'(k);
      if (hits[pos]) begin
        sel = pos;
      end
    end
    return sel;
  endfunction

  function automatic fwd_result_e classify(input logic [ENTRIES-1:0] hits,
                                           input logic [ENTRIES-1:0] parts);
    fwd_result_e res;
    res = FWD_MISS;
    if (|parts) begin
      res = FWD_STALL;
    end else if (|hits) begin
      res = FWD_HIT;
    end
    return res;
  endfunction

  assign res0 = classify(match0, partial0);
  assign res1 = classify(match1, partial1);
  assign idx0 = (res0 == FWD_HIT) ? youngest(match0, tail) : '0;
  assign idx1 = (res1 == FWD_HIT) ? youngest(match1, tail) : '0;

  ////////////////////
  // result registers.
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      chk0_valid <= 1'b0;
      chk1_valid <= 1'b0;
    end else begin
      chk0_valid <= chk0_en;
      chk1_valid <= chk1_en;
    end
  end

  always_ff @(posedge clk) begin
    if (chk0_en) begin
      chk0_result <= res0;
      chk0_idx    <= idx0;
    end
    if (chk1_en) begin
      chk1_result <= res1;
      chk1_idx    <= idx1;
    end
  end

endmodule

`default_nettype wire

//--- stq_fwd_tb.sv
/*
 * testbench for the store-queue forwarding checker.
 * directed tests plus a short random run, checked against a small
 * reference model of the store ring.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_fwd_tb
  import stq_geom_pkg::*;
  import stq_result_pkg::*;
();

  localparam int ENTRIES = 8;
  // ample margin over the few hundred cycles the tests need.
  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic        st_en;
  addr_t       st_addr;
  bank_t       st_banks;
  byte_t       st_bytes;
  logic [2:0]  st_idx;
  logic        st_full;
  logic        data_en;
  logic [2:0]  data_idx;
  logic        commit_en;
  logic        drain_en;
  logic        excpt;
  logic        chk0_en;
  addr_t       chk0_addr;
  bank_t       chk0_banks;
  byte_t       chk0_bytes;
  logic        chk0_valid;
  fwd_result_e chk0_result;
  logic [2:0]  chk0_idx;
  logic        chk1_en;
  addr_t       chk1_addr;
  bank_t       chk1_banks;
  byte_t       chk1_bytes;
  logic        chk1_valid;
  fwd_result_e chk1_result;
  logic [2:0]  chk1_idx;

  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          test_errs;
  string       test_name;
  logic [31:0] lfsr = 32'd88382;

  // reference model of the ring.
  addr_t       m_addr [ENTRIES];
  bank_t       m_banks [ENTRIES];
  byte_t       m_bytes [ENTRIES];
  logic        m_free [ENTRIES];
  logic        m_upd [ENTRIES];
  logic        m_passe [ENTRIES];
  logic [2:0]  m_tail;
  logic [2:0]  m_cmt;
  logic [2:0]  m_head;
  int          m_occ;
  int          m_ncmt;

  stq_fwd_top #(.ENTRIES(ENTRIES)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // random source.
  ////////////////////

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [11:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[10:0], lfsr[0]};
    end
  endtask

  // four line addresses only, so random stores collide often.
  task automatic rand_footprint(output addr_t a, output bank_t b, output byte_t y);
    logic [11:0] r;
    rand_bits(2, r);
    a = 12'h640 | r;
    rand_bits(4, r);
    b = (r[3:0] == 0) ? 4'b0001 : r[3:0];
    rand_bits(4, r);
    y = (r[3:0] == 0) ? 4'b0001 : r[3:0];
  endtask

  ////////////////////
  // stimulus and model.
  ////////////////////

  task automatic next_cycle();
    @(negedge clk);
    st_en     = 1'b0;
    data_en   = 1'b0;
    commit_en = 1'b0;
    drain_en  = 1'b0;
    excpt     = 1'b0;
    chk0_en   = 1'b0;
    chk1_en   = 1'b0;
  endtask

  task automatic store(input addr_t a, input bank_t b, input byte_t y);
    st_en    = 1'b1;
    st_addr  = a;
    st_banks = b;
    st_bytes = y;
    if (m_occ < ENTRIES) begin
      m_addr[m_tail]  = a;
      m_banks[m_tail] = b;
      m_bytes[m_tail] = y;
      m_free[m_tail]  = 1'b0;
      m_upd[m_tail]   = 1'b0;
      m_passe[m_tail] = 1'b0;
      m_tail++;
      m_occ++;
    end
    next_cycle();
  endtask

  task automatic data_arrive(input logic [2:0] i);
    data_en  = 1'b1;
    data_idx = i;
    m_upd[i] = 1'b1;
    next_cycle();
  endtask

  task automatic commit_one();
    commit_en = 1'b1;
    if (m_occ > m_ncmt) begin
      m_passe[m_cmt] = 1'b1;
      m_cmt++;
      m_ncmt++;
    end
    next_cycle();
  endtask

  task automatic drain_one();
    drain_en = 1'b1;
    if (!m_free[m_head] && m_passe[m_head]) begin
      m_free[m_head]  = 1'b1;
      m_passe[m_head] = 1'b0;
      m_head++;
      m_occ--;
      m_ncmt--;
    end
    next_cycle();
  endtask

  task automatic flush_all();
    excpt = 1'b1;
    for (int i = 0; i < ENTRIES; i++) begin
      if (!m_free[i] && !m_passe[i]) begin
        m_free[i] = 1'b1;
      end
    end
    m_tail = m_cmt;
    m_occ  = m_ncmt;
    next_cycle();
  endtask

  task automatic retire_all();
    while (m_occ > m_ncmt) begin
      commit_one();
    end
    while (m_occ > 0) begin
      drain_one();
    end
  endtask

  // stall on any partial overlap, else the youngest full match.
  task automatic predict(input addr_t a, input bank_t b, input byte_t y,
                         output fwd_result_e res, output int idx);
    logic [2:0] pos;
    logic       stall;
    res   = FWD_MISS;
    idx   = 0;
    stall = 1'b0;
    for (int k = 1; k <= ENTRIES; k++) begin
      pos = m_tail - 3'(k);
      if (!m_free[pos] && !m_passe[pos] && m_addr[pos] == a && (m_banks[pos] & b) != 0) begin
        if (m_upd[pos] && (y & ~m_bytes[pos]) == 0) begin
          if (res == FWD_MISS) begin
            res = FWD_HIT;
            idx = pos;
          end
        end else begin
          stall = 1'b1;
        end
      end
    end
    if (stall) begin
      res = FWD_STALL;
    end
  endtask

  ////////////////////
  // checks.
  ////////////////////

  task automatic check_val(input string what, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_result(input string port, input fwd_result_e er, input int ei,
                              input fwd_result_e ar, input int ai);
    checks++;
    if (ar != er) begin
      errors++;
      $display("FAILED %s: %s result expected %s actual %s",
               test_name, port, er.name(), ar.name());
    end else if (er == FWD_HIT) begin
      check_val({port, " index"}, ei, ai);
    end
  endtask

  task automatic check_pair(input addr_t a0, input bank_t b0, input byte_t y0,
                            input addr_t a1, input bank_t b1, input byte_t y1,
                            input fwd_result_e er0, input int ei0,
                            input fwd_result_e er1, input int ei1);
    chk0_en    = 1'b1;
    chk0_addr  = a0;
    chk0_banks = b0;
    chk0_bytes = y0;
    chk1_en    = 1'b1;
    chk1_addr  = a1;
    chk1_banks = b1;
    chk1_bytes = y1;
    next_cycle();
    // the answer is due exactly one clock after the request.
    if (!chk0_valid || !chk1_valid) begin
      errors++;
      $display("%s: no check response one cycle after the request", test_name);
    end else begin
      check_result("chk0", er0, ei0, chk0_result, chk0_idx);
      check_result("chk1", er1, ei1, chk1_result, chk1_idx);
    end
  endtask

  task automatic check_model(input addr_t a0, input bank_t b0, input byte_t y0,
                             input addr_t a1, input bank_t b1, input byte_t y1);
    fwd_result_e er0;
    fwd_result_e er1;
    int          ei0;
    int          ei1;
    predict(a0, b0, y0, er0, ei0);
    predict(a1, b1, y1, er1, ei1);
    check_pair(a0, b0, y0, a1, b1, y1, er0, ei0, er1, ei1);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic end_test();
    if (errors == test_errs) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, errors - test_errs);
    end
  endtask

  ////////////////////
  // tests.
  ////////////////////

  task automatic test_reset();
    begin_test("reset");
    check_val("st_full", 0, st_full);
    check_val("st_idx", 0, st_idx);
    check_val("chk0_valid", 0, chk0_valid);
    check_val("chk1_valid", 0, chk1_valid);
    check_pair(12'h123, 4'b0001, 4'b0001, 12'h456, 4'b1000, 4'b1111,
               FWD_MISS, 0, FWD_MISS, 0);
    next_cycle();
    // valid lasts a single cycle.
    check_val("chk0_valid after answer", 0, chk0_valid);
    check_val("chk1_valid after answer", 0, chk1_valid);
    end_test();
  endtask

  task automatic test_forward();
    begin_test("forward");
    store(12'h2a5, 4'b0001, 4'b0011);
    check_val("st_idx", 1, st_idx);
    data_arrive(3'd0);
    check_pair(12'h2a5, 4'b0001, 4'b0001, 12'h2a5, 4'b0001, 4'b0001, FWD_HIT, 0, FWD_HIT, 0);
    check_pair(12'h2a5, 4'b0011, 4'b0010, 12'h2a5, 4'b0001, 4'b0011, FWD_HIT, 0, FWD_HIT, 0);
    end_test();
  endtask

  task automatic test_stall();
    begin_test("stall");
    store(12'h3c1, 4'b0010, 4'b0001);
    // no data yet on slot 1.
    check_pair(12'h3c1, 4'b0010, 4'b0001, 12'h2a5, 4'b0001, 4'b0001,
               FWD_STALL, 0, FWD_HIT, 0);
    data_arrive(3'd1);
    check_pair(12'h3c1, 4'b0010, 4'b0011, 12'h3c1, 4'b0010, 4'b0001,
               FWD_STALL, 0, FWD_HIT, 1);
    check_pair(12'h3c2, 4'b0010, 4'b0001, 12'h3c1, 4'b0100, 4'b0001,
               FWD_MISS, 0, FWD_MISS, 0);
    end_test();
  endtask

  task automatic test_youngest();
    begin_test("youngest");
    for (int i = 2; i < 5; i++) begin
      store(12'h0f0, 4'b1000, 4'b1111);
      data_arrive(3'(i));
    end
    check_pair(12'h0f0, 4'b1000, 4'b0001, 12'h0f0, 4'b1000, 4'b1111, FWD_HIT, 4, FWD_HIT, 4);
    end_test();
  endtask

  task automatic test_random();
    addr_t       a0;
    addr_t       a1;
    bank_t       b0;
    bank_t       b1;
    byte_t       y0;
    byte_t       y1;
    logic [11:0] r;
    logic [2:0]  slot;
    begin_test("random");
    retire_all();
    // the stores wrap around the end of the ring.
    repeat (6) begin
      rand_footprint(a0, b0, y0);
      slot = m_tail;
      store(a0, b0, y0);
      rand_bits(1, r);
      if (r[0]) begin
        data_arrive(slot);
      end
    end
    repeat (12) begin
      rand_footprint(a0, b0, y0);
      rand_footprint(a1, b1, y1);
      check_model(a0, b0, y0, a1, b1, y1);
    end
    end_test();
  endtask

  task automatic test_retire();
    logic [2:0] sd;
    logic [2:0] sf;
    logic [2:0] start;
    begin_test("retire");
    retire_all();
    sd = m_tail;
    store(12'h555, 4'b0001, 4'b0001);
    data_arrive(sd);
    check_pair(12'h555, 4'b0001, 4'b0001, 12'h555, 4'b0001, 4'b0001, FWD_HIT, sd, FWD_HIT, sd);
    commit_one();
    check_pair(12'h555, 4'b0001, 4'b0001, 12'h555, 4'b0001, 4'b0001, FWD_MISS, 0, FWD_MISS, 0);
    drain_one();
    // a committed store survives the flush and the two after it do not.
    store(12'h6e6, 4'b0010, 4'b0011);
    commit_one();
    sf = m_tail;
    store(12'h7f7, 4'b0100, 4'b1111);
    data_arrive(sf);
    store(12'h7f7, 4'b0100, 4'b1111);
    check_pair(12'h7f7, 4'b0100, 4'b0001, 12'h6e6, 4'b0010, 4'b0001,
               FWD_STALL, 0, FWD_MISS, 0);
    flush_all();
    check_val("st_idx after flush", sf, st_idx);
    check_pair(12'h7f7, 4'b0100, 4'b0001, 12'h7f7, 4'b0100, 4'b1111, FWD_MISS, 0, FWD_MISS, 0);
    drain_one();
    // fill every slot, reusing the drained ones.
    start = m_tail;
    for (int i = 0; i < ENTRIES; i++) begin
      store(12'h700 + 12'(i), 4'b0001, 4'b1111);
      if (i % 2 == 0) begin
        data_arrive(start + 3'(i));
      end
    end
    check_val("st_full", 1, st_full);
    check_val("st_idx when full", start, st_idx);
    check_model(12'h700, 4'b0001, 4'b0001, 12'h701, 4'b0001, 4'b0001);
    store(12'h7ff, 4'b0001, 4'b1111);
    check_val("st_idx after ninth store", start, st_idx);
    check_pair(12'h7ff, 4'b0001, 4'b0001, 12'h700, 4'b0001, 4'b0001,
               FWD_MISS, 0, FWD_HIT, start);
    check_model(12'h707, 4'b0001, 4'b0001, 12'h706, 4'b0001, 4'b0001);
    end_test();
  endtask

  initial begin
    rst        = 1'b1;
    st_addr    = '0;
    st_banks   = '0;
    st_bytes   = '0;
    data_idx   = '0;
    chk0_addr  = '0;
    chk0_banks = '0;
    chk0_bytes = '0;
    chk1_addr  = '0;
    chk1_banks = '0;
    chk1_bytes = '0;
    st_en      = 1'b0;
    data_en    = 1'b0;
    commit_en  = 1'b0;
    drain_en   = 1'b0;
    excpt      = 1'b0;
    chk0_en    = 1'b0;
    chk1_en    = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_free[i]  = 1'b1;
      m_upd[i]   = 1'b0;
      m_passe[i] = 1'b0;
    end
    m_tail = '0;
    m_cmt  = '0;
    m_head = '0;
    m_occ  = 0;
    m_ncmt = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    next_cycle();
    test_reset();
    test_forward();
    test_stall();
    test_youngest();
    test_random();
    test_retire();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- stq_fwd_top.sv
/*
 * store-queue forwarding checker.
 * ring of in-flight stores with two independent load-check ports that
 * answer hit, stall or miss one clock after the request.
 */

`timescale 1ns/1ps
`default_nettype none

module stq_fwd_top
  import stq_geom_pkg::*;
  import stq_result_pkg::*;
#(
  parameter int ENTRIES = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       st_en,
  input  addr_t                      st_addr,
  input  bank_t                      st_banks,
  input  byte_t                      st_bytes,
  output logic [$clog2(ENTRIES)-1:0] st_idx,
  output logic                       st_full,
  input  logic                       data_en,
  input  logic [$clog2(ENTRIES)-1:0] data_idx,
  input  logic                       commit_en,
  input  logic                       drain_en,
  input  logic                       excpt,
  input  logic                       chk0_en,
  input  addr_t                      chk0_addr,
  input  bank_t                      chk0_banks,
  input  byte_t                      chk0_bytes,
  output logic                       chk0_valid,
  output fwd_result_e                chk0_result,
  output logic [$clog2(ENTRIES)-1:0] chk0_idx,
  input  logic                       chk1_en,
  input  addr_t                      chk1_addr,
  input  bank_t                      chk1_banks,
  input  byte_t                      chk1_bytes,
  output logic                       chk1_valid,
  output fwd_result_e                chk1_result,
  output logic [$clog2(ENTRIES)-1:0] chk1_idx
);

  localparam int IDX_W = $clog2(ENTRIES);

  logic [ENTRIES-1:0] wrt_en;
  logic [ENTRIES-1:0] commit_set;
  logic [ENTRIES-1:0] free_set;
  logic [ENTRIES-1:0] free;
  logic [ENTRIES-1:0] passe;
  logic [ENTRIES-1:0] addr_hit0;
  logic [ENTRIES-1:0] addr_hit1;
  logic [ENTRIES-1:0] match0;
  logic [ENTRIES-1:0] partial0;
  logic [ENTRIES-1:0] match1;
  logic [ENTRIES-1:0] partial1;
  logic               flush;
  logic [IDX_W-1:0]   tail;

  // the next store goes to the allocation pointer.
  assign st_idx = tail;

  stq_alloc #(.ENTRIES(ENTRIES)) alloc0 (
    .clk(clk), .rst(rst),
    .st_en(st_en), .commit_en(commit_en), .drain_en(drain_en), .excpt(excpt),
    .free(free), .passe(passe),
    .wrt_en(wrt_en), .commit_set(commit_set), .free_set(free_set),
    .flush(flush), .tail(tail), .st_full(st_full)
  );

  stq_addr_cam #(.ENTRIES(ENTRIES)) cam0 (
    .clk(clk), .rst(rst), .wrt_en(wrt_en), .st_addr(st_addr),
    .chk0_addr(chk0_addr), .chk1_addr(chk1_addr),
    .addr_hit0(addr_hit0), .addr_hit1(addr_hit1)
  );

  for (genvar t = 0; t < ENTRIES; t++) begin : g_entry
    stq_entry #(.ENTRIES(ENTRIES), .IDX(t)) entry0 (
      .clk(clk), .rst(rst),
      .wrt_en(wrt_en[t]), .banks(st_banks), .bytes(st_bytes),
      .data_en(data_en), .data_idx(data_idx),
      .commit_set(commit_set[t]), .free_set(free_set[t]), .flush(flush),
      .addr_hit0(addr_hit0[t]), .addr_hit1(addr_hit1[t]),
      .chk0_en(chk0_en), .chk0_banks(chk0_banks), .chk0_bytes(chk0_bytes),
      .chk1_en(chk1_en), .chk1_banks(chk1_banks), .chk1_bytes(chk1_bytes),
      .match0(match0[t]), .partial0(partial0[t]),
      .match1(match1[t]), .partial1(partial1[t]),
      .free(free[t]), .passe(passe[t])
    );
  end

  stq_fwd_select #(.ENTRIES(ENTRIES)) sel0 (
    .clk(clk), .rst(rst), .tail(tail),
    .chk0_en(chk0_en), .chk1_en(chk1_en),
    .match0(match0), .partial0(partial0),
    .match1(match1), .partial1(partial1),
    .chk0_valid(chk0_valid), .chk1_valid(chk1_valid),
    .chk0_result(chk0_result), .chk1_result(chk1_result),
    .chk0_idx(chk0_idx), .chk1_idx(chk1_idx)
  );

endmodule

`default_nettype wire

//--- stq_geom_pkg.sv
/*
 * store-queue geometry.
 * widths and types for the footprint of a store or a load:
 * the line address, the bank mask and the byte mask inside a bank word.
 */

`default_nettype none

package stq_geom_pkg;

  ////////////////////
  // widths.
  ////////////////////

  localparam int ADDR_W = 12;
  localparam int BANK_W = 4;
  localparam int BYTE_W = 4;

  ////////////////////
  // footprint types.
  ////////////////////

  // line address of a store or a load.
  typedef logic [ADDR_W-1:0] addr_t;

  // one bit per bank touched, one or more bits set.
  typedef logic [BANK_W-1:0] bank_t;

  // bytes touched inside a bank word.
  typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

//--- stq_result_pkg.sv
/*
 * store-to-load forwarding result.
 * the answer returned by each check port of the store queue.
 */

`default_nettype none

package stq_result_pkg;

  // stall covers both a partial overlap and data not yet arrived.
  typedef enum logic [1:0] {
    FWD_MISS  = 2'd0,
    FWD_HIT   = 2'd1,
    FWD_STALL = 2'd2
  } fwd_result_e;

endpackage

`default_nettype wire
